/* design/nrisc_core_ctrl.sv */
// Holds instr until pc.step is seen; no interrupts, no stall input, no host interface
`timescale 1ns/100ps

module nrisc_core_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  nrisc_isa_pkg::instr_u       instr,
  input  nrisc_isa_pkg::alu_flags_t   flags,
  output nrisc_ctrl_pkg::alu_ctrl_t   alu,
  output nrisc_ctrl_pkg::reg_ctrl_t   regs,
  output nrisc_ctrl_pkg::mem_ctrl_t   mem,
  output nrisc_ctrl_pkg::stack_ctrl_t stack,
  output nrisc_ctrl_pkg::pc_ctrl_t    pc
);
  import nrisc_ctrl_pkg::*;

  ctrl_word_t first_word;   // Decoded phase one
  ctrl_word_t second_word;  // Decoded phase two
  logic       two_phase;

  // Opcode and flag decode
  nrisc_decoder i_nrisc_decoder (
    .instr     (instr),
    .flags     (flags),
    .first     (first_word),
    .second    (second_word),
    .two_phase (two_phase)
  );

  // Phase sequencing and output registers
  nrisc_sequencer i_nrisc_sequencer (
    .clk       (clk),
    .reset     (reset),
    .first     (first_word),
    .second    (second_word),
    .two_phase (two_phase),
    .alu       (alu),
    .regs      (regs),
    .mem       (mem),
    .stack     (stack),
    .pc        (pc)
  );

endmodule

/* design/nrisc_ctrl_pkg.sv */
// Control bus types; all strobes are active high and are meant to last one clock
`include "nrisc_consts.svh"

package nrisc_ctrl_pkg;

  // ALU select
  typedef struct packed {
    nrisc_isa_pkg::alu_op_e op;
    logic                   inc_dec;  // Second operand forced to one
  } alu_ctrl_t;

  // Register file ports and write-data muxing
  typedef struct packed {
    logic [`NRISC_REG_IDX_W-1:0] rd;        // Write port
    logic [`NRISC_REG_IDX_W-1:0] rf1;       // ALU operand A
    logic [`NRISC_REG_IDX_W-1:0] rf2;       // ALU operand B
    logic                        write;     // Strobe
    logic                        imm_sel;   // Write data from the LI immediate
    logic                        data_sel;  // Write data from data memory
  } reg_ctrl_t;

  // Data memory strobes
  typedef struct packed {
    logic load;
    logic write;
    logic addr_strobe;  // Latch the ALU result as address
  } mem_ctrl_t;

  // Return stack
  typedef struct packed {
    logic push;
    logic pop;
  } stack_ctrl_t;

  // Next PC source
  typedef enum logic [1:0] {
    PC_INCR = 2'd0,  // PC + 1
    PC_JUMP = 2'd1,  // ALU result
    PC_POP  = 2'd2   // Stack top
  } pc_sel_e;

  typedef struct packed {
    pc_sel_e sel;
    logic    step;  // PC update, also ends the instruction
  } pc_ctrl_t;

  // Everything the sequencer registers in one cycle
  typedef struct packed {
    alu_ctrl_t   alu;
    reg_ctrl_t   regs;
    mem_ctrl_t   mem;
    stack_ctrl_t stack;
    pc_ctrl_t    pc;
  } ctrl_word_t;

  // Sequencer phase
  typedef enum logic [1:0] {
    EXEC   = 2'd0,
    MEM    = 2'd1,
    BRANCH = 2'd2
  } seq_state_e;

endpackage

/* design/nrisc_decoder.sv */
// Purely combinational; flags must be valid in the same cycle as the jump word they qualify
`timescale 1ns/100ps

module nrisc_decoder (
  input  nrisc_isa_pkg::instr_u      instr,
  input  nrisc_isa_pkg::alu_flags_t  flags,
  output nrisc_ctrl_pkg::ctrl_word_t first,      // Phase one
  output nrisc_ctrl_pkg::ctrl_word_t second,     // Phase two, ignored unless two_phase
  output logic                       two_phase
);
  import nrisc_isa_pkg::*;
  import nrisc_ctrl_pkg::*;

  instr_reg_t r_form;     // Register reading
  instr_imm_t i_form;     // LI reading
  logic       taken;      // Jump condition met
  logic       rotate;     // RTR/RTL instead of SHR/SHL
  ctrl_word_t addr_word;  // rs1 + rs2 on the ALU, no strobes

  assign r_form = instr.reg_form;
  assign i_form = instr.imm_form;

  // Conditions from the flags
  always_comb begin
    case (r_form.opcode)
      OP_JMP:  taken = 1'b1;
      OP_JZ:   taken = flags.zero;
      OP_JC:   taken = flags.carry;
      OP_JM:   taken = flags.minus;
      default: taken = 1'b0;
    endcase
  end

  // Rotate select is bit 0 of the word, shifts only
  assign rotate = (r_form.opcode inside {OP_SHR, OP_SHL}) & r_form.rs2[0];

  // Address or jump target calculation
  always_comb begin
    addr_word          = '0;
    addr_word.alu.op   = ALU_ADD;
    addr_word.regs.rf1 = r_form.rs1;
    addr_word.regs.rf2 = r_form.rs2;
  end

  always_comb begin
    first     = '0;  // Default is a no-op that only steps
    second    = '0;
    two_phase = 1'b0;
    case (r_form.opcode)
      OP_CORE: begin
        case (core_sub_e'(r_form.rd))
          CORE_CALL: begin
            first            = addr_word;
            first.stack.push = 1'b1;  // Return address saved first
            second           = addr_word;  // Keep target on the ALU output
            second.pc.sel    = PC_JUMP;
            two_phase        = 1'b1;
          end
          CORE_RET: begin
            first.stack.pop = 1'b1;
            second.pc.sel   = PC_POP;  // PC loads the popped top
            two_phase       = 1'b1;
          end
          default: ;  // Reserved codes
        endcase
      end
      OP_LW: begin
        first                = addr_word;
        second               = addr_word;  // Address held while reading
        second.mem.load        = 1'b1;
        second.mem.addr_strobe = 1'b1;
        second.regs.rd       = r_form.rd;
        second.regs.data_sel = 1'b1;       // Memory data into rd
        second.regs.write    = 1'b1;
        two_phase            = 1'b1;
      end
      OP_SW: begin
        first                  = addr_word;
        second.alu.op          = ALU_AND;    // rd AND rd passes the store data
        second.regs.rf1        = r_form.rd;
        second.regs.rf2        = r_form.rd;
        second.mem.write       = 1'b1;
        second.mem.addr_strobe = 1'b1;
        two_phase              = 1'b1;
      end
      OP_LI: begin
        first.regs.rd      = i_form.rd;
        first.regs.imm_sel = 1'b1;
        first.regs.write   = 1'b1;
      end
      OP_JMP, OP_JZ, OP_JC, OP_JM: begin
        if (taken) begin
          first         = addr_word;
          second        = addr_word;
          second.pc.sel = PC_JUMP;
          two_phase     = 1'b1;
        end
      end
      OP_UNARY: begin
        first.regs.rd  = r_form.rd;
        first.regs.rf1 = r_form.rs1;
        case (unary_sub_e'(r_form.rs2))
          UN_NOT: begin
            first.alu.op     = ALU_NOT;
            first.regs.write = 1'b1;
          end
          UN_INC: begin
            first.alu.op      = ALU_ADD;
            first.alu.inc_dec = 1'b1;
            first.regs.write  = 1'b1;
          end
          UN_DEC: begin
            first.alu.op      = ALU_SUB;
            first.alu.inc_dec = 1'b1;
            first.regs.write  = 1'b1;
          end
          default: ;  // TWC and reserved, no write
        endcase
      end
      default: begin
        // ADD..SHL, low opcode bits line up with the ALU code
        first.alu.op     = alu_op_e'({rotate, r_form.opcode[2:0]});
        first.regs.rd    = r_form.rd;
        first.regs.rf1   = r_form.rs1;
        first.regs.rf2   = r_form.rs2;
        first.regs.write = 1'b1;
      end
    endcase
    second.pc.step = 1'b1;  // Phase two always closes the instruction
  end

endmodule

/* design/nrisc_isa_pkg.sv */
// ISA types only; HALT, WAIT, SLEEP, RETI and TWC have no encoding here and decode as no-ops
`include "nrisc_consts.svh"

package nrisc_isa_pkg;

  // Major opcodes, top nibble of the word
  typedef enum logic [`NRISC_OPCODE_W-1:0] {
    OP_CORE  = 4'h0,  // Sub-op in the rd field
    OP_LW    = 4'h1,
    OP_SW    = 4'h2,
    OP_LI    = 4'h3,
    OP_JMP   = 4'h4,
    OP_JZ    = 4'h5,
    OP_JC    = 4'h6,
    OP_JM    = 4'h7,
    OP_ADD   = 4'h8,  // ALU group starts here
    OP_SUB   = 4'h9,
    OP_AND   = 4'hA,
    OP_OR    = 4'hB,
    OP_XOR   = 4'hC,
    OP_SHR   = 4'hD,
    OP_SHL   = 4'hE,
    OP_UNARY = 4'hF   // Sub-op in the rs2 field
  } opcode_e;

  // Core group, codes other than these are reserved
  typedef enum logic [`NRISC_REG_IDX_W-1:0] {
    CORE_CALL = 4'h4,
    CORE_RET  = 4'h5
  } core_sub_e;

  // Unary group
  typedef enum logic [`NRISC_REG_IDX_W-1:0] {
    UN_NOT = 4'h0,
    UN_TWC = 4'h1,  // Never implemented in hardware
    UN_INC = 4'h2,
    UN_DEC = 4'h3
  } unary_sub_e;

  // ALU function codes
  typedef enum logic [`NRISC_ALU_OP_W-1:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ALU_SHR = 4'h5,  // Bit 3 set gives RTR
    ALU_SHL = 4'h6,  // Bit 3 set gives RTL
    ALU_NOT = 4'h7
  } alu_op_e;

  // Three-register form
  typedef struct packed {
    opcode_e                     opcode;
    logic [`NRISC_REG_IDX_W-1:0] rd;
    logic [`NRISC_REG_IDX_W-1:0] rs1;
    logic [`NRISC_REG_IDX_W-1:0] rs2;
  } instr_reg_t;

  // LI form, immediate in the low byte
  typedef struct packed {
    opcode_e                     opcode;
    logic [`NRISC_REG_IDX_W-1:0] rd;
    logic [`NRISC_IMM_W-1:0]     imm;
  } instr_imm_t;

  // One word, two readings
  typedef union packed {
    instr_reg_t reg_form;
    instr_imm_t imm_form;
  } instr_u;

  // Flags from the ALU, carry on the MSB
  typedef struct packed {
    logic carry;
    logic zero;
    logic minus;
  } alu_flags_t;

endpackage

/* design/nrisc_sequencer.sv */
// Control outputs are registered one edge after decode; no wait states, memory must answer in one cycle
`timescale 1ns/100ps

module nrisc_sequencer (
  input  logic                        clk,
  input  logic                        reset,
  input  nrisc_ctrl_pkg::ctrl_word_t  first,
  input  nrisc_ctrl_pkg::ctrl_word_t  second,
  input  logic                        two_phase,
  output nrisc_ctrl_pkg::alu_ctrl_t   alu,
  output nrisc_ctrl_pkg::reg_ctrl_t   regs,
  output nrisc_ctrl_pkg::mem_ctrl_t   mem,
  output nrisc_ctrl_pkg::stack_ctrl_t stack,
  output nrisc_ctrl_pkg::pc_ctrl_t    pc
);
  import nrisc_ctrl_pkg::*;

  seq_state_e state;
  ctrl_word_t phase2_word;  // Captured at decode
  ctrl_word_t next_word;    // What the next edge registers
  ctrl_word_t ctrl_q;       // Output register

  // Phase one in EXEC, saved word otherwise
  always_comb begin
    if (state == EXEC) begin
      next_word         = first;
      next_word.pc.step = ~two_phase;  // Single phase steps right away
    end else begin
      next_word = phase2_word;
    end
  end

  // State and outputs
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= EXEC;
      ctrl_q <= '0;  // All strobes low
    end else begin
      ctrl_q <= next_word;
      case (state)
        EXEC: begin
          if (two_phase) begin
            // Memory ops carry addr_strobe in phase two
            state <= second.mem.addr_strobe ? MEM : BRANCH;
          end
        end
        MEM, BRANCH: state <= EXEC;  // Phase two takes one cycle
        default:     state <= EXEC;
      endcase
    end
  end

  // Phase two saved so instr may change once step is seen
  always_ff @(posedge clk) begin
    if ((state == EXEC) && two_phase) begin
      phase2_word <= second;
    end
  end

  assign alu   = ctrl_q.alu;
  assign regs  = ctrl_q.regs;
  assign mem   = ctrl_q.mem;
  assign stack = ctrl_q.stack;
  assign pc    = ctrl_q.pc;

endmodule

/* include/nrisc_consts.svh */
// Widths of the 16-bit core only; opcode plus three register fields must fill one word
`ifndef NRISC_CONSTS_SVH
`define NRISC_CONSTS_SVH

// Instruction word
`define NRISC_WORD_W 16

// Register file index, 16 registers
`define NRISC_REG_IDX_W 4

// Major opcode in the top nibble
`define NRISC_OPCODE_W 4

// ALU function code, bit 3 selects rotate on shifts
`define NRISC_ALU_OP_W 4

// LI immediate, low byte of the word
`define NRISC_IMM_W 8

`endif

/* list.f */
+incdir+include
design/nrisc_isa_pkg.sv
design/nrisc_ctrl_pkg.sv
design/nrisc_decoder.sv
design/nrisc_sequencer.sv
design/nrisc_core_ctrl.sv
verification/nrisc_core_ctrl_assertions.sv
verification/nrisc_core_ctrl_tb.sv

/* verification/nrisc_core_ctrl_assertions.sv */
// Strobe rules of the sequencer outputs, sampled on the rising edge; quiet while reset is high
`timescale 1ns/100ps

module nrisc_core_ctrl_assertions (
  input logic                        clk,
  input logic                        reset,
  input nrisc_ctrl_pkg::reg_ctrl_t   regs,
  input nrisc_ctrl_pkg::mem_ctrl_t   mem,
  input nrisc_ctrl_pkg::stack_ctrl_t stack,
  input nrisc_ctrl_pkg::pc_ctrl_t    pc
);
  logic [6:0] strobes;  // All one-cycle strobes
  int failures = 0;     // Failed assertion count

  assign strobes = {regs.write, mem.load, mem.write, mem.addr_strobe,
                    stack.push, stack.pop, pc.step};

  // Reset clears everything
  reset_clears: assert property (@(posedge clk) reset |=> (strobes == '0))
    else begin
      failures++;
      $error("strobe high in the cycle after a reset edge");
    end

  // Phase one never lasts longer than one cycle
  step_follows: assert property (@(posedge clk) disable iff (reset)
      (!pc.step && !$past(reset)) |=> pc.step)
    else begin
      failures++;
      $error("no pc.step in the cycle after a phase-one cycle");
    end

  load_write_excl: assert property (@(posedge clk) disable iff (reset)
      !(mem.load && mem.write))
    else begin
      failures++;
      $error("memory load and write high together");
    end

  // Push and pop belong to phase one only
  stack_no_step: assert property (@(posedge clk) disable iff (reset)
      (stack.push || stack.pop) |-> !pc.step)
    else begin
      failures++;
      $error("stack push or pop in a cycle with pc.step");
    end

endmodule

bind nrisc_sequencer nrisc_core_ctrl_assertions i_nrisc_core_ctrl_assertions (
  .clk   (clk),
  .reset (reset),
  .regs  (regs),
  .mem   (mem),
  .stack (stack),
  .pc    (pc)
);

/* verification/nrisc_core_ctrl_tb.sv */
// Stimulus from a 16-bit LFSR with a fixed seed; expects at most two phases per instruction
`timescale 1ns/100ps
`include "nrisc_consts.svh"

module nrisc_core_ctrl_tb;
  import nrisc_isa_pkg::*;
  import nrisc_ctrl_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int N_ALU  = 32;  // Four rounds over ADD..UNARY
  localparam int N_LI   = 8;
  localparam int N_MEM  = 16;
  localparam int N_JMP  = 24;
  localparam int N_CORE = 6;   // CALL, RET, reserved in turn
  // Two cycles per instruction at most, plus the no-op after the jumps
  localparam int CYCLE_LIMIT = (N_ALU + N_LI + N_MEM + N_JMP + N_CORE + 1) * 3 + RESET_CYCLES;

  logic        clk;
  logic        reset;
  instr_u      instr;
  alu_flags_t  flags;
  alu_ctrl_t   alu;
  reg_ctrl_t   regs;
  mem_ctrl_t   mem;
  stack_ctrl_t stack;
  pc_ctrl_t    pc;

  logic [15:0] lfsr;  // Generator state
  int errors;
  int checks;
  int tests;
  int tests_failed;
  int step_count;     // Steps in cycles already closed
  int cycles;

  nrisc_core_ctrl i_nrisc_core_ctrl (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Output of the previous cycle, sampled before the registers update
  always @(posedge clk) begin
    if (reset) begin
      step_count <= 0;
    end else if (pc.step) begin
      step_count <= step_count + 1;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      bits = {bits[14:0], lfsr[0]};
    end
    return bits;
  endfunction

  function automatic instr_u random_word(input opcode_e op);
    instr_u w;
    w.reg_form.opcode = op;
    w.reg_form.rd     = 4'(lfsr_bits(4));
    w.reg_form.rs1    = 4'(lfsr_bits(4));  // Also the LI immediate
    w.reg_form.rs2    = 4'(lfsr_bits(4));
    return w;
  endfunction

  // Expected phase words, built from the instruction rules
  function automatic void expected_words(input instr_u w, input alu_flags_t f,
                                         output ctrl_word_t ph1, output ctrl_word_t ph2,
                                         output logic two);
    opcode_e                     op;
    logic [`NRISC_REG_IDX_W-1:0] rd;
    logic [`NRISC_REG_IDX_W-1:0] rs1;
    logic [`NRISC_REG_IDX_W-1:0] rs2;
    logic [`NRISC_ALU_OP_W-1:0]  code;
    ctrl_word_t                  addr;
    logic                        taken;
    op  = w.reg_form.opcode;
    rd  = w.reg_form.rd;
    rs1 = w.reg_form.rs1;
    rs2 = w.reg_form.rs2;
    ph1 = '0;
    ph2 = '0;
    two = 1'b0;
    addr          = '0;
    addr.alu.op   = ALU_ADD;  // rs1 + rs2
    addr.regs.rf1 = rs1;
    addr.regs.rf2 = rs2;
    taken = (op == OP_JMP) || (op == OP_JZ && f.zero) ||
            (op == OP_JC && f.carry) || (op == OP_JM && f.minus);
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHR, OP_SHL: begin
        code = 4'(op - OP_ADD);  // Same order as the ALU codes
        if (op == OP_SHR || op == OP_SHL) code[3] = rs2[0];
        ph1.alu.op     = alu_op_e'(code);
        ph1.regs.rd    = rd;
        ph1.regs.rf1   = rs1;
        ph1.regs.rf2   = rs2;
        ph1.regs.write = 1'b1;
      end
      OP_UNARY: begin
        ph1.alu.op      = (rs2 == UN_NOT) ? ALU_NOT : (rs2 == UN_DEC) ? ALU_SUB : ALU_ADD;
        ph1.alu.inc_dec = (rs2 == UN_INC) || (rs2 == UN_DEC);
        ph1.regs.rd     = rd;
        ph1.regs.rf1    = rs1;
        ph1.regs.write  = (rs2 == UN_NOT) || ph1.alu.inc_dec;  // TWC writes nothing
      end
      OP_LI: begin
        ph1.regs.rd      = w.imm_form.rd;
        ph1.regs.imm_sel = 1'b1;
        ph1.regs.write   = 1'b1;
      end
      OP_LW: begin
        two                 = 1'b1;
        ph1                 = addr;
        ph2                 = addr;  // Address held for the read
        ph2.mem.load        = 1'b1;
        ph2.mem.addr_strobe = 1'b1;
        ph2.regs.rd         = rd;
        ph2.regs.data_sel   = 1'b1;
        ph2.regs.write      = 1'b1;
      end
      OP_SW: begin
        two                 = 1'b1;
        ph1                 = addr;
        ph2.alu.op          = ALU_AND;  // rd passed through as store data
        ph2.regs.rf1        = rd;
        ph2.regs.rf2        = rd;
        ph2.mem.write       = 1'b1;
        ph2.mem.addr_strobe = 1'b1;
      end
      OP_JMP, OP_JZ, OP_JC, OP_JM: begin
        if (taken) begin
          two        = 1'b1;
          ph1        = addr;
          ph2        = addr;
          ph2.pc.sel = PC_JUMP;
        end
      end
      OP_CORE: begin
        if (rd == CORE_CALL) begin
          two            = 1'b1;
          ph1            = addr;
          ph1.stack.push = 1'b1;
          ph2            = addr;
          ph2.pc.sel     = PC_JUMP;
        end else if (rd == CORE_RET) begin
          two           = 1'b1;
          ph1.stack.pop = 1'b1;
          ph2.pc.sel    = PC_POP;
        end
      end
    endcase
    ph1.pc.step = ~two;
    ph2.pc.step = 1'b1;
  endfunction

  // Drive one word, check each phase up to pc.step
  task automatic run_instr(input instr_u w, input alu_flags_t f);
    ctrl_word_t ph1;
    ctrl_word_t ph2;
    ctrl_word_t seen;
    ctrl_word_t want;
    logic       two;
    int         phase;
    opcode_e    op;
    expected_words(w, f, ph1, ph2, two);
    op    = w.reg_form.opcode;
    instr = w;
    flags = f;
    phase = 0;
    do begin
      @(negedge clk);
      phase++;
      seen = {alu, regs, mem, stack, pc};
      want = (phase == 1) ? ph1 : ph2;
      checks++;
      assert (seen === want) else begin
        $display("Fail at %0t ns: %s word %h phase %0d got %h, expected %h",
                 $time, op.name(), w, phase, seen, want);
        errors++;
      end
    end while (!pc.step);
    checks++;
    assert (phase == (two ? 2 : 1)) else begin
      $display("Fail at %0t ns: %s word %h took %0d phases", $time, op.name(), w, phase);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int count, input int errors_before);
    tests++;
    if (errors != errors_before) tests_failed++;
    $display("Test %s: %0d instructions, %0d errors", name, count, errors - errors_before);
  endtask

  initial begin
    instr_u     w;
    alu_flags_t f;
    ctrl_word_t seen;
    ctrl_word_t ph1;
    ctrl_word_t ph2;
    logic       two;
    int         base;
    int         start;
    int         span;
    int         mark;
    lfsr         = 16'd35401;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    tests_failed = 0;
    reset        = 1'b1;
    instr        = '0;
    flags        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);

    mark = errors;
    seen = {alu, regs, mem, stack, pc};
    checks++;
    assert (seen === '0) else begin
      $display("Fail at %0t ns: outputs %h while in reset", $time, seen);
      errors++;
    end
    reset = 1'b0;
    end_test("reset", 0, mark);

    mark = errors;
    for (int i = 0; i < N_ALU; i++) begin
      w = random_word(opcode_e'(4'(8 + i % 8)));
      case (i % 8)
        5, 6:    w.reg_form.rs2[0] = i[3];     // Shift, then rotate
        7:       w.reg_form.rs2 = 4'(i / 8);   // NOT, TWC, INC, DEC
        default: ;
      endcase
      run_instr(w, alu_flags_t'(3'(lfsr_bits(3))));
    end
    end_test("alu", N_ALU, mark);

    mark = errors;
    for (int i = 0; i < N_LI; i++) begin
      run_instr(random_word(OP_LI), alu_flags_t'(3'(lfsr_bits(3))));
    end
    end_test("li", N_LI, mark);

    mark = errors;
    for (int i = 0; i < N_MEM; i++) begin
      w = random_word((lfsr_bits(1) != 0) ? OP_SW : OP_LW);
      run_instr(w, alu_flags_t'(3'(lfsr_bits(3))));
    end
    end_test("load_store", N_MEM, mark);

    mark  = errors;
    base  = step_count + int'(pc.step);  // Steps up to this cycle
    start = cycles;
    span  = 1;  // Reserved core op after the last jump
    for (int i = 0; i < N_JMP; i++) begin
      w = random_word(opcode_e'(4'(4 + lfsr_bits(2))));
      f = alu_flags_t'(3'(lfsr_bits(3)));
      expected_words(w, f, ph1, ph2, two);
      span += two ? 2 : 1;  // Cycles this jump should take
      run_instr(w, f);
    end
    instr = '0;  // Reserved core op, one phase
    @(posedge clk);
    @(negedge clk);
    checks++;
    assert ((step_count - base == N_JMP) && (cycles - start == span)) else begin
      $display("Fail at %0t ns: %0d steps in %0d cycles for %0d jumps, expected %0d cycles",
               $time, step_count - base, cycles - start, N_JMP, span);
      errors++;
    end
    end_test("jumps", N_JMP, mark);

    mark = errors;
    for (int i = 0; i < N_CORE; i++) begin
      w = random_word(OP_CORE);
      w.reg_form.rd = (i % 3 == 2) ? 4'(lfsr_bits(4) | 16'h8) : 4'(4 + i % 3);
      run_instr(w, alu_flags_t'(3'(lfsr_bits(3))));
    end
    end_test("call_ret", N_CORE, mark);

    errors += i_nrisc_core_ctrl.i_nrisc_sequencer.i_nrisc_core_ctrl_assertions.failures;
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
